/* Bender.yml */
package:
  name: addsub_core

sources:
  - files:
      - verilog/ooo_pkg.sv
      - verilog/tag_counter.sv
      - verilog/tag_file.sv
      - verilog/issue_ctrl.sv
      - verilog/alu_station.sv
      - verilog/addsub_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/addsub_core_tb.sv

/* compile.f */
+incdir+include
verilog/ooo_pkg.sv
verilog/tag_counter.sv
verilog/tag_file.sv
verilog/issue_ctrl.sv
verilog/alu_station.sv
verilog/addsub_core.sv
verification/addsub_core_tb.sv

/* include/tb_vectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: op, use_imm, sl2, rd, rs, rt, imm, random result_ready, result_ready pattern
// Pattern bit k drives result_ready in the k-th cycle of a row, high after eight cycles
task automatic load_vectors();
	// Immediates into r1 to r7, negative ones too
	add_row(ooo_pkg::OP_ADD, 1, 0, 1, 0, 0, 16'h0005, 0, 8'hff);
	add_row(ooo_pkg::OP_ADD, 1, 0, 2, 0, 0, 16'hfffd, 0, 8'hff);
	add_row(ooo_pkg::OP_ADD, 1, 0, 3, 0, 0, 16'h7fff, 0, 8'hff);
	add_row(ooo_pkg::OP_ADD, 1, 0, 4, 0, 0, 16'h8000, 0, 8'hff);
	add_row(ooo_pkg::OP_ADD, 1, 0, 5, 0, 0, 16'h0064, 0, 8'hff);
	add_row(ooo_pkg::OP_ADD, 1, 0, 6, 0, 0, 16'hff00, 0, 8'hff);
	add_row(ooo_pkg::OP_ADD, 1, 0, 7, 0, 0, 16'h0001, 0, 8'hff);
	// Dependent chains
	add_row(ooo_pkg::OP_ADD, 0, 0, 1, 2, 1, 16'h0000, 0, 8'hff);
	add_row(ooo_pkg::OP_ADD, 0, 0, 2, 1, 1, 16'h0000, 0, 8'hff);
	add_row(ooo_pkg::OP_ADD, 1, 0, 3, 2, 0, 16'h0007, 0, 8'hff);
	add_row(ooo_pkg::OP_SUB, 0, 0, 3, 4, 3, 16'h0000, 0, 8'hff);
	add_row(ooo_pkg::OP_ADD, 1, 0, 4, 3, 0, 16'h0001, 0, 8'hff);
	add_row(ooo_pkg::OP_ADD, 1, 0, 4, 4, 0, 16'h0001, 0, 8'hff);
	// Shifted b, ready at issue, then arriving late under back-pressure
	add_row(ooo_pkg::OP_SUB, 0, 1, 5, 6, 5, 16'h0000, 0, 8'hff);
	add_row(ooo_pkg::OP_ADD, 1, 0, 6, 0, 0, 16'h1234, 0, 8'hff);
	add_row(ooo_pkg::OP_ADD, 0, 1, 7, 6, 7, 16'h0000, 0, 8'hff);
	add_row(ooo_pkg::OP_SUB, 1, 1, 1, 7, 0, 16'hffff, 0, 8'h00);
	add_row(ooo_pkg::OP_ADD, 0, 1, 2, 1, 2, 16'h0000, 0, 8'h00);
	add_row(ooo_pkg::OP_SUB, 0, 1, 0, 2, 3, 16'h0000, 0, 8'h0f);
	// Random back-pressure
	add_row(ooo_pkg::OP_ADD, 0, 0, 1, 0, 1, 16'h0000, 1, 8'h00);
	add_row(ooo_pkg::OP_SUB, 1, 1, 2, 1, 0, 16'h0010, 1, 8'h00);
	add_row(ooo_pkg::OP_SUB, 0, 1, 4, 3, 2, 16'h0000, 1, 8'h00);
	add_row(ooo_pkg::OP_ADD, 1, 0, 5, 4, 0, 16'h8001, 1, 8'h00);
	// Result port held low until the machine stalls
	add_row(ooo_pkg::OP_ADD, 1, 0, 1, 0, 0, 16'h0011, 0, 8'h00);
	add_row(ooo_pkg::OP_ADD, 0, 0, 2, 1, 1, 16'h0000, 0, 8'h00);
	add_row(ooo_pkg::OP_SUB, 0, 1, 3, 2, 1, 16'h0000, 0, 8'h00);
	add_row(ooo_pkg::OP_ADD, 1, 0, 4, 3, 0, 16'hfff0, 0, 8'h00);
	add_row(ooo_pkg::OP_ADD, 0, 0, 5, 4, 2, 16'h0000, 0, 8'h00);
	add_row(ooo_pkg::OP_SUB, 0, 1, 6, 5, 4, 16'h0000, 0, 8'h00);
endtask

`endif

/* verification/addsub_core_tb.sv */
`timescale 1ns/1ns

module addsub_core_tb;

	logic              clk = 1'b0;
	logic              arst_n;
	ooo_pkg::inst_t    inst;
	logic              inst_valid;
	logic              result_ready;
	logic              inst_ready;
	ooo_pkg::cdb_t     result;

	ooo_pkg::inst_t    vec_inst [$];
	logic              vec_rand [$];
	logic [7:0]        vec_pat [$];

	ooo_pkg::word_t    model_regs [ooo_pkg::REG_COUNT];
	ooo_pkg::word_t    exp_data [ooo_pkg::TAG_COUNT];
	logic              exp_pending [ooo_pkg::TAG_COUNT];
	int                accepted = 0;
	int                results = 0;
	int                data_errs = 0;
	int                tag_errs = 0;
	int                other_errs = 0;
	integer            seed = 32'hfabb_6cf1;

	addsub_core dut (
		.clk          (clk),
		.arst_n       (arst_n),
		.inst         (inst),
		.inst_valid   (inst_valid),
		.result_ready (result_ready),
		.inst_ready   (inst_ready),
		.result       (result)
	);

	always #50 clk = ~clk;

	task automatic add_row(input ooo_pkg::alu_op_e op, input logic use_imm, input logic sl2,
			input ooo_pkg::reg_idx_t rd, input ooo_pkg::reg_idx_t rs,
			input ooo_pkg::reg_idx_t rt, input ooo_pkg::imm_t imm,
			input logic rnd, input logic [7:0] pat);
		ooo_pkg::inst_t row;
		row.op      = op;
		row.use_imm = use_imm;
		row.sl2     = sl2;
		row.rd      = rd;
		row.rs      = rs;
		row.rt      = rt;
		row.imm     = imm;
		vec_inst.push_back(row);
		vec_rand.push_back(rnd);
		vec_pat.push_back(pat);
	endtask

	`include "tb_vectors.svh"

	function automatic logic ready_bit(input int r, input int k, input int rnd);
		if (vec_rand[r]) begin
			return rnd[0];
		end
		if (k < 8) begin
			return vec_pat[r][k];
		end
		return 1'b1;
	endfunction

	// In-order model, tags handed out in acceptance order
	task automatic model_accept(input ooo_pkg::inst_t i);
		ooo_pkg::word_t a;
		ooo_pkg::word_t b;
		ooo_pkg::tag_t  tag;
		a = i.use_imm ? {{(ooo_pkg::DATA_W - 16){i.imm[15]}}, i.imm} : model_regs[i.rt];
		b = model_regs[i.rs];
		if (i.sl2) begin
			b = {b[ooo_pkg::DATA_W-3:0], 2'b00};
		end
		tag = ooo_pkg::tag_t'(accepted % ooo_pkg::TAG_COUNT);
		if (exp_pending[tag]) begin
			other_errs++;
			$display("Tag %0d reused at %0t while its result is still pending", tag, $time);
		end
		exp_data[tag]    = i.op == ooo_pkg::OP_SUB ? a - b : a + b;
		exp_pending[tag] = 1'b1;
		model_regs[i.rd] = exp_data[tag];
		accepted++;
		if (accepted - results > ooo_pkg::TAG_COUNT) begin
			other_errs++;
			$display("More than %0d instructions in flight at %0t", ooo_pkg::TAG_COUNT, $time);
		end
	endtask

	task automatic check_word(input ooo_pkg::tag_t tag, input ooo_pkg::word_t got,
			input ooo_pkg::word_t expected);
		if (got !== expected) begin
			data_errs++;
			$display("FAIL %0t: tag %0d result %h, expected %h", $time, tag, got, expected);
		end
	endtask

	task automatic check_tag_seen(input ooo_pkg::tag_t tag, output logic known);
		known = exp_pending[tag] === 1'b1;
		if (!known) begin
			tag_errs++;
			$display("FAIL %0t: result on tag %0d with no pending instruction", $time, tag);
		end
	endtask

	task automatic report_counts();
		$display("Errors: %0d data, %0d tag, %0d other (%0d instructions, %0d results)",
			data_errs, tag_errs, other_errs, accepted, results);
	endtask

	// Holds one row until the DUT takes it
	task automatic apply_row(input int r);
		int   k;
		logic taken;
		k = 0;
		taken = 1'b0;
		inst         <= vec_inst[r];
		inst_valid   <= 1'b1;
		result_ready <= ready_bit(r, k, $random(seed));
		while (!taken) begin
			@(negedge clk);
			taken = inst_ready;
			@(posedge clk);
			k++;
			if (taken) begin
				model_accept(vec_inst[r]);
			end else begin
				result_ready <= ready_bit(r, k, $random(seed));
			end
		end
	endtask

	always @(negedge clk) begin
		logic known;
		if (arst_n && result.valid && result_ready) begin
			check_tag_seen(result.tag, known);
			if (known) begin
				check_word(result.tag, result.data, exp_data[result.tag]);
				exp_pending[result.tag] = 1'b0;
			end
			results++;
		end
	end

	initial begin
		arst_n       = 1'b0;
		inst         = '0;
		inst_valid   = 1'b0;
		result_ready = 1'b0;
		for (int i = 0; i < ooo_pkg::REG_COUNT; i++) begin
			model_regs[i] = '0;
		end
		for (int i = 0; i < ooo_pkg::TAG_COUNT; i++) begin
			exp_pending[i] = 1'b0;
		end
		load_vectors();
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		if (result.valid !== 1'b0 || inst_ready !== 1'b1) begin
			other_errs++;
			$display("FAIL %0t: after reset result.valid %b, inst_ready %b", $time,
				result.valid, inst_ready);
		end
		@(posedge clk);
		for (int r = 0; r < vec_inst.size(); r++) begin
			apply_row(r);
		end
		inst_valid   <= 1'b0;
		result_ready <= 1'b1;
		while (results < accepted) begin
			@(negedge clk);
		end
		// Quiet bus expected from here on
		repeat (4) @(negedge clk);
		report_counts();
		if (data_errs + tag_errs + other_errs == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	initial begin
		@(posedge clk);
		repeat (vec_inst.size() * 40 + 200) @(posedge clk);
		other_errs++;
		$display("Timeout: the run did not finish within the cycle limit");
		report_counts();
		$display("Some tests failed");
		$finish;
	end

endmodule

/* verilog/addsub_core.sv */
`timescale 1ns/1ns

module addsub_core (
	input  logic           clk,
	input  logic           arst_n,
	input  ooo_pkg::inst_t inst,
	input  logic           inst_valid,
	input  logic           result_ready,
	output logic           inst_ready,
	output ooo_pkg::cdb_t  result
);
	ooo_pkg::operand_t       rs_operand;
	ooo_pkg::operand_t       rt_operand;
	ooo_pkg::reg_idx_t       rs_idx;
	ooo_pkg::reg_idx_t       rt_idx;
	ooo_pkg::reg_idx_t       issue_rd;
	ooo_pkg::station_entry_t entry;
	ooo_pkg::tag_t           next_tag;
	ooo_pkg::cdb_t           cdb;
	logic                    entry_valid;
	logic                    entry_ready;
	logic                    issue_fire;
	logic                    tag_avail;

	issue_ctrl u_issue_ctrl (
		.clk          (clk),
		.arst_n       (arst_n),
		.inst         (inst),
		.inst_valid   (inst_valid),
		.rs_operand   (rs_operand),
		.rt_operand   (rt_operand),
		.cdb          (cdb),
		.result_ready (result_ready),
		.entry_ready  (entry_ready),
		.tag_avail    (tag_avail),
		.next_tag     (next_tag),
		.inst_ready   (inst_ready),
		.rs_idx       (rs_idx),
		.rt_idx       (rt_idx),
		.entry        (entry),
		.entry_valid  (entry_valid),
		.issue_fire   (issue_fire),
		.issue_rd     (issue_rd)
	);

	tag_counter u_tag_counter (
		.clk          (clk),
		.arst_n       (arst_n),
		.issue_fire   (issue_fire),
		.cdb          (cdb),
		.result_ready (result_ready),
		.next_tag     (next_tag),
		.tag_avail    (tag_avail)
	);

	tag_file u_tag_file (
		.clk          (clk),
		.arst_n       (arst_n),
		.rs_idx       (rs_idx),
		.rt_idx       (rt_idx),
		.issue_fire   (issue_fire),
		.issue_rd     (issue_rd),
		.next_tag     (next_tag),
		.cdb          (cdb),
		.result_ready (result_ready),
		.rs_operand   (rs_operand),
		.rt_operand   (rt_operand)
	);

	alu_station u_alu_station (
		.clk          (clk),
		.arst_n       (arst_n),
		.entry        (entry),
		.entry_valid  (entry_valid),
		.result_ready (result_ready),
		.entry_ready  (entry_ready),
		.cdb          (cdb)
	);

	assign result = cdb;

endmodule

/* verilog/alu_station.sv */
`timescale 1ns/1ns

module alu_station (
	input  logic                    clk,
	input  logic                    arst_n,
	input  ooo_pkg::station_entry_t entry,
	input  logic                    entry_valid,
	input  logic                    result_ready,
	output logic                    entry_ready,
	output ooo_pkg::cdb_t           cdb
);
	ooo_pkg::station_entry_t              slot_q   [ooo_pkg::STATION_DEPTH];
	ooo_pkg::station_entry_t              slot_upd [ooo_pkg::STATION_DEPTH];
	ooo_pkg::station_entry_t              slot_nxt [ooo_pkg::STATION_DEPTH];
	logic [ooo_pkg::STATION_DEPTH-1:0]    slot_valid_q;
	logic [ooo_pkg::STATION_DEPTH-1:0]    slot_valid_nxt;
	logic [ooo_pkg::STATION_DEPTH-1:0]    slot_ready;
	ooo_pkg::station_entry_t              picked;
	int                                   pick;
	logic                                 dispatch;
	logic                                 entry_fire;
	logic                                 cdb_accept;
	logic                                 res_valid_q;
	ooo_pkg::tag_t                        res_tag_q;
	ooo_pkg::word_t                       res_data_q;

	assign cdb_accept = res_valid_q && result_ready;

	// Waiting operands capture the accepted result
	always_comb begin
		for (int j = 0; j < ooo_pkg::STATION_DEPTH; j++) begin
			slot_upd[j] = slot_q[j];
			if (!slot_q[j].a.ready && cdb_accept && slot_q[j].a.tag == res_tag_q) begin
				slot_upd[j].a.ready = 1'b1;
				slot_upd[j].a.value = res_data_q;
			end
			if (!slot_q[j].b.ready && cdb_accept && slot_q[j].b.tag == res_tag_q) begin
				slot_upd[j].b.ready = 1'b1;
				slot_upd[j].b.value = slot_q[j].sl2 ? res_data_q << 2 : res_data_q;
			end
			slot_ready[j] = slot_valid_q[j] && slot_q[j].a.ready && slot_q[j].b.ready;
		end
	end

	// Lowest index is oldest
	always_comb begin
		pick = 0;
		for (int j = ooo_pkg::STATION_DEPTH - 1; j >= 0; j--) begin
			if (slot_ready[j]) begin
				pick = j;
			end
		end
	end

	assign picked      = slot_q[pick];
	assign dispatch    = |slot_ready && (!res_valid_q || result_ready);
	assign entry_ready = !slot_valid_q[ooo_pkg::STATION_DEPTH-1] || dispatch;
	assign entry_fire  = entry_valid && entry_ready;

	// Close the gap left by a dispatch, new entry goes behind
	always_comb begin
		int n;
		n = 0;
		slot_valid_nxt = '0;
		slot_nxt = slot_upd;
		for (int j = 0; j < ooo_pkg::STATION_DEPTH; j++) begin
			if (slot_valid_q[j] && !(dispatch && pick == j)) begin
				slot_nxt[n]       = slot_upd[j];
				slot_valid_nxt[n] = 1'b1;
				n++;
			end
		end
		if (entry_fire) begin
			slot_nxt[n]       = entry;
			slot_valid_nxt[n] = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			slot_valid_q <= '0;
			res_valid_q  <= 1'b0;
		end else begin
			slot_valid_q <= slot_valid_nxt;
			if (dispatch) begin
				res_valid_q <= 1'b1;
			end else if (result_ready) begin
				res_valid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		slot_q <= slot_nxt;
		if (dispatch) begin
			res_tag_q  <= picked.tag;
			res_data_q <= picked.op == ooo_pkg::OP_SUB ? picked.a.value - picked.b.value
			                                           : picked.a.value + picked.b.value;
		end
	end

	assign cdb.valid = res_valid_q;
	assign cdb.tag   = res_tag_q;
	assign cdb.data  = res_data_q;

	// Refused entry must stay offered, never dropped into a full station
	a_no_overwrite: assert property (@(posedge clk) disable iff (!arst_n)
		entry_valid && !entry_ready |=> entry_valid);

endmodule

/* verilog/issue_ctrl.sv */
`timescale 1ns/1ns

module issue_ctrl (
	input  logic                    clk,
	input  logic                    arst_n,
	input  ooo_pkg::inst_t          inst,
	input  logic                    inst_valid,
	input  ooo_pkg::operand_t       rs_operand,
	input  ooo_pkg::operand_t       rt_operand,
	input  ooo_pkg::cdb_t           cdb,
	input  logic                    result_ready,
	input  logic                    entry_ready,
	input  logic                    tag_avail,
	input  ooo_pkg::tag_t           next_tag,
	output logic                    inst_ready,
	output ooo_pkg::reg_idx_t       rs_idx,
	output ooo_pkg::reg_idx_t       rt_idx,
	output ooo_pkg::station_entry_t entry,
	output logic                    entry_valid,
	output logic                    issue_fire,
	output ooo_pkg::reg_idx_t       issue_rd
);
	ooo_pkg::issue_state_e state_q;
	ooo_pkg::inst_t        inst_q;
	ooo_pkg::operand_t     rs_live;
	ooo_pkg::operand_t     rt_live;
	logic                  inst_fire;
	logic                  cdb_accept;

	// Result on the bus this cycle is not yet in the tag file
	function automatic ooo_pkg::operand_t bypass(
		input ooo_pkg::operand_t src,
		input ooo_pkg::cdb_t     bus,
		input logic              accept
	);
		ooo_pkg::operand_t res;
		res = src;
		if (!src.ready && accept && src.tag == bus.tag) begin
			res.ready = 1'b1;
			res.value = bus.data;
		end
		return res;
	endfunction

	assign cdb_accept = cdb.valid && result_ready;
	assign rs_idx     = inst_q.rs;
	assign rt_idx     = inst_q.rt;
	assign issue_rd   = inst_q.rd;
	assign rs_live    = bypass(rs_operand, cdb, cdb_accept);
	assign rt_live    = bypass(rt_operand, cdb, cdb_accept);

	// No free tag keeps the entry off the station port
	assign entry_valid = state_q != ooo_pkg::ISSUE_IDLE && tag_avail;
	assign issue_fire  = entry_valid && entry_ready;
	assign inst_ready  = state_q == ooo_pkg::ISSUE_IDLE ||
	                     (state_q == ooo_pkg::ISSUE_HOLD && issue_fire);
	assign inst_fire   = inst_valid && inst_ready;

	always_comb begin
		entry.tag = next_tag;
		entry.op  = inst_q.op;
		entry.sl2 = inst_q.sl2;
		entry.a   = rt_live;
		if (inst_q.use_imm) begin
			entry.a.ready = 1'b1;
			entry.a.tag   = '0;
			entry.a.value = ooo_pkg::word_t'($signed(inst_q.imm));
		end
		entry.b = rs_live;
		// Pending b gets its shift when captured in the station
		if (rs_live.ready && inst_q.sl2) begin
			entry.b.value = rs_live.value << 2;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= ooo_pkg::ISSUE_IDLE;
		end else begin
			case (state_q)
				ooo_pkg::ISSUE_IDLE: begin
					if (inst_fire) begin
						state_q <= ooo_pkg::ISSUE_READY;
					end
				end
				ooo_pkg::ISSUE_READY: begin
					state_q <= issue_fire ? ooo_pkg::ISSUE_IDLE : ooo_pkg::ISSUE_HOLD;
				end
				ooo_pkg::ISSUE_HOLD: begin
					if (issue_fire) begin
						state_q <= inst_fire ? ooo_pkg::ISSUE_READY : ooo_pkg::ISSUE_IDLE;
					end
				end
				default: state_q <= ooo_pkg::ISSUE_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (inst_fire) begin
			inst_q <= inst;
		end
	end

	a_idle_no_entry: assert property (@(posedge clk) disable iff (!arst_n)
		state_q == ooo_pkg::ISSUE_IDLE |-> !entry_valid);

endmodule

/* verilog/ooo_pkg.sv */
package ooo_pkg;

	// Machine sizes
	localparam int DATA_W        = 32;
	localparam int REG_COUNT     = 8;
	localparam int TAG_COUNT     = 8;
	localparam int STATION_DEPTH = 2;

	localparam int IMM_W      = 16;
	localparam int REG_IDX_W  = $clog2(REG_COUNT);
	localparam int TAG_W      = $clog2(TAG_COUNT);
	localparam int INFLIGHT_W = $clog2(TAG_COUNT + 1);

	typedef logic [DATA_W-1:0]     word_t;
	typedef logic [REG_IDX_W-1:0]  reg_idx_t;
	typedef logic [TAG_W-1:0]      tag_t;
	typedef logic [IMM_W-1:0]      imm_t;
	typedef logic [INFLIGHT_W-1:0] inflight_t;

	typedef enum logic {
		OP_ADD,
		OP_SUB
	} alu_op_e;

	typedef enum logic [1:0] {
		ISSUE_IDLE,
		ISSUE_READY,
		ISSUE_HOLD
	} issue_state_e;

	// One instruction as it arrives in program order
	typedef struct packed {
		alu_op_e  op;
		logic     use_imm;
		logic     sl2;
		reg_idx_t rd;
		reg_idx_t rs;
		reg_idx_t rt;
		imm_t     imm;
	} inst_t;

	// Source value, or the tag it is still waiting for
	typedef struct packed {
		logic  ready;
		tag_t  tag;
		word_t value;
	} operand_t;

	typedef struct packed {
		tag_t     tag;
		alu_op_e  op;
		logic     sl2;
		operand_t a;
		operand_t b;
	} station_entry_t;

	typedef struct packed {
		logic  valid;
		tag_t  tag;
		word_t data;
	} cdb_t;

endpackage

/* verilog/tag_counter.sv */
`timescale 1ns/1ns

module tag_counter (
	input  logic          clk,
	input  logic          arst_n,
	input  logic          issue_fire,
	input  ooo_pkg::cdb_t cdb,
	input  logic          result_ready,
	output ooo_pkg::tag_t next_tag,
	output logic          tag_avail
);
	ooo_pkg::inflight_t count_q;
	logic               cdb_accept;

	assign cdb_accept = cdb.valid && result_ready;
	assign tag_avail  = count_q != ooo_pkg::inflight_t'(ooo_pkg::TAG_COUNT);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			next_tag <= '0;
			count_q  <= '0;
		end else begin
			// Tag space is a power of two, so the pointer wraps by itself
			if (issue_fire) begin
				next_tag <= next_tag + 1'b1;
			end
			case ({issue_fire, cdb_accept})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	a_count_max: assert property (@(posedge clk) disable iff (!arst_n)
		count_q <= ooo_pkg::inflight_t'(ooo_pkg::TAG_COUNT));

	// Every accepted result belongs to an issued instruction
	a_count_min: assert property (@(posedge clk) disable iff (!arst_n)
		cdb_accept |-> count_q != '0);

endmodule

/* verilog/tag_file.sv */
`timescale 1ns/1ns

module tag_file (
	input  logic              clk,
	input  logic              arst_n,
	input  ooo_pkg::reg_idx_t rs_idx,
	input  ooo_pkg::reg_idx_t rt_idx,
	input  logic              issue_fire,
	input  ooo_pkg::reg_idx_t issue_rd,
	input  ooo_pkg::tag_t     next_tag,
	input  ooo_pkg::cdb_t     cdb,
	input  logic              result_ready,
	output ooo_pkg::operand_t rs_operand,
	output ooo_pkg::operand_t rt_operand
);
	ooo_pkg::operand_t                 regs_q [ooo_pkg::REG_COUNT];
	logic [ooo_pkg::REG_COUNT-1:0]     rename;
	logic [ooo_pkg::REG_COUNT-1:0]     wake;
	logic                              cdb_accept;

	assign cdb_accept = cdb.valid && result_ready;

	// Reads see the state before this cycle's rename
	assign rs_operand = regs_q[rs_idx];
	assign rt_operand = regs_q[rt_idx];

	always_comb begin
		for (int i = 0; i < ooo_pkg::REG_COUNT; i++) begin
			rename[i] = issue_fire && issue_rd == ooo_pkg::reg_idx_t'(i);
			wake[i]   = cdb_accept && !regs_q[i].ready && regs_q[i].tag == cdb.tag;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < ooo_pkg::REG_COUNT; i++) begin
				regs_q[i].ready <= 1'b1;
				regs_q[i].tag   <= '0;
				regs_q[i].value <= '0;
			end
		end else begin
			for (int i = 0; i < ooo_pkg::REG_COUNT; i++) begin
				// Newer producer wins over a result for the old one
				if (rename[i]) begin
					regs_q[i].ready <= 1'b0;
					regs_q[i].tag   <= next_tag;
				end else if (wake[i]) begin
					regs_q[i].ready <= 1'b1;
					regs_q[i].value <= cdb.data;
				end
			end
		end
	end

	// At most one register can wait on any in-flight tag
	a_single_owner: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0(wake));

endmodule
